// File: Makefile
TOP  := soc_bus_tb
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS) tb.f
	verilator --binary --assert -j 0 --top-module $(TOP) -f tb.f

# The log decides pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bus_controller.sv
module bus_controller import bus_pkg::*; (
  input  logic              clock_50,
  input  logic              rst,
  input  addr_t             address,
  input  logic              read,
  input  logic              write,
  output logic              wait_req,
  output logic [NUM_CS-1:0] chipselect,
  output logic              ram_read,
  output logic              ram_write,
  output logic              uart_read,
  output logic              uart_write,
  input  word_t             ram_readdata,
  input  word_t             uart_readdata,
  output word_t             readdata
);

  typedef enum logic {
    S_IDLE,
    S_ACCESS
  } state_t;

  state_t              state;
  region_t             region;
  logic [NUM_CS-1:0]   cs_decode;
  logic                access_req;
  logic                in_access;

  assign region     = address[REGION_MSB:REGION_LSB];
  assign access_req = read | write;
  assign in_access  = (state == S_ACCESS);

  // One-hot or zero select from the region field
  always_comb begin
    cs_decode = '0;
    case (region)
      REGION_RAM:  cs_decode[CS_RAM] = 1'b1;
      REGION_UART: cs_decode[CS_UART] = 1'b1;
      default:     cs_decode = '0;
    endcase
  end

  // First cycle of an access raises wait, second cycle completes it
  always_ff @(posedge clock_50) begin
    if (rst) begin
      state      <= S_IDLE;
      chipselect <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (access_req) begin
            state      <= S_ACCESS;
            chipselect <= cs_decode;
          end
        end
        S_ACCESS: begin
          state      <= S_IDLE;
          chipselect <= '0;
        end
        default: begin
          state      <= S_IDLE;
          chipselect <= '0;
        end
      endcase
    end
  end

  assign wait_req = access_req && (state == S_IDLE);

  // Slave strobes only in the second cycle
  assign ram_read   = in_access && read && chipselect[CS_RAM];
  assign ram_write  = in_access && write && chipselect[CS_RAM];
  assign uart_read  = in_access && read && chipselect[CS_UART];
  assign uart_write = in_access && write && chipselect[CS_UART];

  // Unmapped accesses read back zero
  assign readdata = (chipselect[CS_RAM]  ? ram_readdata  : '0) |
                    (chipselect[CS_UART] ? uart_readdata : '0);

endmodule

// File: bus_pkg.sv
package bus_pkg;

  // Bus word and address types
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Bit i enables byte i of the word
  typedef logic [3:0] be_t;

  // Top nibble of the address selects the region
  typedef logic [3:0] region_t;

  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  // Address map, everything else is unmapped
  localparam region_t REGION_RAM  = 4'h0;
  localparam region_t REGION_UART = 4'h2;

  // Chip select vector layout
  localparam int NUM_CS  = 2;
  localparam int CS_RAM  = 0;
  localparam int CS_UART = 1;

endpackage

// File: scratch_ram.sv
module scratch_ram import bus_pkg::*; #(
  parameter  int RAM_WORDS = 1024,
  localparam int AW        = $clog2(RAM_WORDS)
) (
  input  logic          clock_50,
  input  logic [AW-1:0] word_addr,
  input  word_t         writedata,
  input  be_t           be,
  input  logic          ram_read,
  input  logic          ram_write,
  output word_t         ram_readdata
);

  localparam int NUM_BYTES = $bits(be_t);

  word_t mem [RAM_WORDS];
  word_t rd_word;

  // Byte lanes are written independently
  always_ff @(posedge clock_50) begin
    if (ram_write) begin
      for (int i = 0; i < NUM_BYTES; i++) begin
        if (be[i]) begin
          mem[word_addr][8*i +: 8] <= writedata[8*i +: 8];
        end
      end
    end
  end

  // Latched every cycle, ready by the second cycle of the access
  always_ff @(posedge clock_50) begin
    rd_word <= mem[word_addr];
  end

  assign ram_readdata = ram_read ? rd_word : '0;

endmodule

// File: soc_bus.sv
module soc_bus import bus_pkg::*; #(
  parameter int RAM_WORDS    = 1024,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clock_50,
  input  logic  rst,
  input  addr_t address,
  input  logic  read,
  input  logic  write,
  input  be_t   be,
  input  word_t writedata,
  output word_t readdata,
  output logic  wait_req,
  output logic  tx
);

  localparam int RAM_AW = $clog2(RAM_WORDS);

  logic [NUM_CS-1:0] chipselect;
  logic              ram_read;
  logic              ram_write;
  logic              uart_read;
  logic              uart_write;
  word_t             ram_readdata;
  word_t             uart_readdata;

  bus_controller bc0 (
    .clock_50      (clock_50),
    .rst           (rst),
    .address       (address),
    .read          (read),
    .write         (write),
    .wait_req      (wait_req),
    .chipselect    (chipselect),
    .ram_read      (ram_read),
    .ram_write     (ram_write),
    .uart_read     (uart_read),
    .uart_write    (uart_write),
    .ram_readdata  (ram_readdata),
    .uart_readdata (uart_readdata),
    .readdata      (readdata)
  );

  // Word address drops the byte offset bits
  scratch_ram #(.RAM_WORDS(RAM_WORDS)) ram0 (
    .clock_50     (clock_50),
    .word_addr    (address[RAM_AW+1:2]),
    .writedata    (writedata),
    .be           (be),
    .ram_read     (ram_read),
    .ram_write    (ram_write),
    .ram_readdata (ram_readdata)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart0 (
    .clock_50      (clock_50),
    .rst           (rst),
    .reg_sel       (address[2]),
    .writedata     (writedata),
    .be            (be),
    .uart_read     (uart_read),
    .uart_write    (uart_write),
    .uart_readdata (uart_readdata),
    .tx            (tx)
  );

endmodule

// File: soc_bus_properties.sv
module soc_bus_properties import bus_pkg::*; (
  input logic              clock_50,
  input logic              rst,
  input logic              wait_req,
  input logic [NUM_CS-1:0] chipselect,
  input logic              ram_read,
  input logic              ram_write,
  input logic              uart_read,
  input logic              uart_write
);

  int wait_fails   = 0;
  int cs_fails     = 0;
  int strobe_fails = 0;

  logic any_strobe;

  assign any_strobe = ram_read | ram_write | uart_read | uart_write;

  // Wait covers only the first cycle of an access
  wait_one_cycle: assert property (
    @(posedge clock_50) disable iff (rst) wait_req |=> !wait_req
  ) else begin
    wait_fails++;
    $error("wait_req stayed high for a second cycle");
  end

  cs_not_two_hot: assert property (
    @(posedge clock_50) disable iff (rst) $onehot0(chipselect)
  ) else begin
    cs_fails++;
    $error("more than one chip select active: %b", chipselect);
  end

  // Strobes belong to the second cycle only
  strobe_without_wait: assert property (
    @(posedge clock_50) disable iff (rst) any_strobe |-> !wait_req
  ) else begin
    strobe_fails++;
    $error("slave strobe issued while wait_req is high");
  end

endmodule

// File: soc_bus_tb.sv
module soc_bus_tb
  import bus_pkg::*, uart_pkg::*;
();

  localparam int RAM_WORDS    = 256;
  localparam int CLKS_PER_BIT = 8;
  localparam int MAX_CYCLES   = 4000;
  localparam int WAIT_LIMIT   = 4;
  localparam int START_LIMIT  = 4 * CLKS_PER_BIT;
  localparam int SEED         = 31;

  localparam addr_t UART_DATA_ADDR   = {REGION_UART, 25'h0, UART_DATA_OFS};
  localparam addr_t UART_STATUS_ADDR = {REGION_UART, 25'h0, UART_STATUS_OFS};

  logic  clock_50;
  logic  rst;
  addr_t address;
  logic  read;
  logic  write;
  be_t   be;
  word_t writedata;
  word_t readdata;
  logic  wait_req;
  logic  tx;

  // Expected contents of the written RAM locations
  word_t ram_model [int unsigned];
  int    cycle_count = 0;

  tb_clock clk0 (
    .clock_50 (clock_50),
    .rst      (rst)
  );

  soc_bus #(
    .RAM_WORDS    (RAM_WORDS),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) dut0 (
    .clock_50  (clock_50),
    .rst       (rst),
    .address   (address),
    .read      (read),
    .write     (write),
    .be        (be),
    .writedata (writedata),
    .readdata  (readdata),
    .wait_req  (wait_req),
    .tx        (tx)
  );

  bind bus_controller soc_bus_properties props0 (
    .clock_50   (clock_50),
    .rst        (rst),
    .wait_req   (wait_req),
    .chipselect (chipselect),
    .ram_read   (ram_read),
    .ram_write  (ram_write),
    .uart_read  (uart_read),
    .uart_write (uart_write)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clock_50) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      stop_on_error($sformatf("Timeout, run exceeded %0d cycles", MAX_CYCLES));
    end
  end

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
    end
  endtask

  function automatic addr_t region_word_addr(input region_t region, input int unsigned idx);
    return {region, 28'(idx << 2)};
  endfunction

  // Byte lane i comes from the new word where byte_en[i] is set
  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input be_t byte_en);
    word_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (byte_en[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // Drive one access, wait for wait_req low, then release the strobe
  task automatic bus_access(input string name, input addr_t addr, input logic is_read,
                            input be_t byte_en, input word_t wdata, output word_t rdata);
    int wait_cycles;
    @(posedge clock_50);
    #1;
    address     = addr;
    read        = is_read;
    write       = !is_read;
    be          = byte_en;
    writedata   = wdata;
    wait_cycles = 0;
    @(negedge clock_50);
    while (wait_req) begin
      wait_cycles++;
      if (wait_cycles > WAIT_LIMIT) begin
        stop_on_error($sformatf("%s: wait_req never dropped for address %h", name, addr));
      end
      @(negedge clock_50);
    end
    // Exactly one wait cycle before completion
    check_word({name, " wait cycles"}, word_t'(1), word_t'(wait_cycles));
    rdata = readdata;
    @(posedge clock_50);
    #1;
    read  = 1'b0;
    write = 1'b0;
  endtask

  task automatic bus_write(input string name, input addr_t addr, input be_t byte_en,
                           input word_t data);
    word_t ignored;
    bus_access(name, addr, 1'b0, byte_en, data, ignored);
  endtask

  task automatic bus_read(input string name, input addr_t addr, output word_t data);
    bus_access(name, addr, 1'b1, 4'hF, '0, data);
  endtask

  // Samples mid-bit, counting from the first low cycle on tx
  task automatic check_frame(input string name, input logic [7:0] byte_val);
    int waited;
    waited = 0;
    @(negedge clock_50);
    while (tx) begin
      waited++;
      if (waited > START_LIMIT) begin
        stop_on_error($sformatf("%s: no start bit seen on tx", name));
      end
      @(negedge clock_50);
    end
    repeat (CLKS_PER_BIT / 2) @(negedge clock_50);
    check_bit({name, " start bit"}, 1'b0, tx);
    // Data goes out LSB first
    for (int b = 0; b < 8; b++) begin
      repeat (CLKS_PER_BIT) @(negedge clock_50);
      check_bit({name, " data bit"}, byte_val[b], tx);
    end
    repeat (CLKS_PER_BIT) @(negedge clock_50);
    check_bit({name, " stop bit"}, 1'b1, tx);
    repeat (CLKS_PER_BIT - CLKS_PER_BIT / 2) @(negedge clock_50);
  endtask

  task automatic reset_state();
    word_t got;
    @(negedge clock_50);
    check_bit("reset_state", 1'b0, wait_req);
    check_bit("reset_state", 1'b1, tx);
    bus_read("reset_state", UART_STATUS_ADDR, got);
    check_word("reset_state", '0, got);
  endtask

  task automatic ram_round_trip();
    int unsigned idx_list [$];
    int unsigned idx;
    word_t       data;
    word_t       got;
    repeat (32) begin
      idx  = $urandom % RAM_WORDS;
      data = $urandom;
      ram_model[idx] = data;
      idx_list.push_back(idx);
      bus_write("ram_round_trip", region_word_addr(REGION_RAM, idx), 4'hF, data);
    end
    foreach (idx_list[i]) begin
      bus_read("ram_round_trip", region_word_addr(REGION_RAM, idx_list[i]), got);
      check_word("ram_round_trip", ram_model[idx_list[i]], got);
    end
  endtask

  task automatic byte_enables();
    be_t         masks [$];
    int unsigned idx;
    word_t       data;
    word_t       got;
    masks = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'hA, 4'h3, 4'hC};
    idx   = $urandom % RAM_WORDS;
    data  = $urandom;
    ram_model[idx] = data;
    bus_write("byte_enables", region_word_addr(REGION_RAM, idx), 4'hF, data);
    foreach (masks[i]) begin
      data = $urandom;
      ram_model[idx] = merge_bytes(ram_model[idx], data, masks[i]);
      bus_write("byte_enables", region_word_addr(REGION_RAM, idx), masks[i], data);
      bus_read("byte_enables", region_word_addr(REGION_RAM, idx), got);
      check_word("byte_enables", ram_model[idx], got);
    end
  endtask

  // Same low address bits as a RAM word, so a stray write would land in RAM
  task automatic unmapped_region();
    int unsigned idx;
    word_t       got;
    idx = $urandom % RAM_WORDS;
    ram_model[idx] = $urandom;
    bus_write("unmapped_region", region_word_addr(REGION_RAM, idx), 4'hF, ram_model[idx]);
    bus_read("unmapped_region", region_word_addr(4'h1, idx), got);
    check_word("unmapped_region", '0, got);
    bus_read("unmapped_region", region_word_addr(4'h5, idx), got);
    check_word("unmapped_region", '0, got);
    bus_write("unmapped_region", region_word_addr(4'h1, idx), 4'hF, ~ram_model[idx]);
    bus_write("unmapped_region", region_word_addr(4'h5, idx), 4'hF, ~ram_model[idx]);
    bus_read("unmapped_region", region_word_addr(REGION_RAM, idx), got);
    check_word("unmapped_region", ram_model[idx], got);
  endtask

  task automatic serial_frame();
    logic [7:0] byte_val;
    word_t      got;
    byte_val = 8'($urandom);
    bus_write("serial_frame", UART_DATA_ADDR, 4'h1, {24'h0, byte_val});
    check_frame("serial_frame", byte_val);
    // Data register is write only
    bus_read("serial_frame", UART_DATA_ADDR, got);
    check_word("serial_frame", '0, got);
  endtask

  task automatic busy_handling();
    logic [7:0] first_byte;
    logic [7:0] second_byte;
    word_t      busy_word;
    word_t      got;
    first_byte  = 8'($urandom);
    second_byte = ~first_byte;
    busy_word   = '0;
    busy_word[STATUS_BUSY] = 1'b1;
    bus_write("busy_handling", UART_DATA_ADDR, 4'h1, {24'h0, first_byte});
    fork
      check_frame("busy_handling", first_byte);
      begin
        bus_read("busy_handling", UART_STATUS_ADDR, got);
        check_word("busy_handling", busy_word, got);
        bus_write("busy_handling", UART_DATA_ADDR, 4'h1, {24'h0, second_byte});
        bus_read("busy_handling", UART_STATUS_ADDR, got);
        check_word("busy_handling", busy_word, got);
      end
    join
    bus_read("busy_handling", UART_STATUS_ADDR, got);
    check_word("busy_handling", '0, got);
    // Dropped byte must never reach the line
    repeat (FRAME_BITS * CLKS_PER_BIT) begin
      @(negedge clock_50);
      check_bit("busy_handling", 1'b1, tx);
    end
  endtask

  initial begin
    int assert_fails;
    void'($urandom(SEED));
    address   = '0;
    read      = 1'b0;
    write     = 1'b0;
    be        = '0;
    writedata = '0;
    @(posedge clock_50);
    while (rst) begin
      @(posedge clock_50);
    end
    reset_state();
    ram_round_trip();
    byte_enables();
    unmapped_region();
    serial_frame();
    busy_handling();
    assert_fails = dut0.bc0.props0.wait_fails + dut0.bc0.props0.cs_fails +
                   dut0.bc0.props0.strobe_fails;
    if (assert_fails != 0) begin
      stop_on_error($sformatf("%0d bus controller assertions failed", assert_fails));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: tb.f
bus_pkg.sv
uart_pkg.sv
bus_controller.sv
scratch_ram.sv
uart_tx.sv
soc_bus.sv
tb_clock.sv
soc_bus_properties.sv
soc_bus_tb.sv

// File: tb_clock.sv
module tb_clock (
  output logic clock_50,
  output logic rst
);

  initial begin
    clock_50 = 1'b0;
    forever #2 clock_50 = ~clock_50;
  end

  // Reset held over the first 3 rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clock_50);
    #1 rst = 1'b0;
  end

endmodule

// File: uart_pkg.sv
package uart_pkg;

  // Register byte offsets, the slave only decodes address bit 2
  localparam logic [2:0] UART_DATA_OFS   = 3'h0;
  localparam logic [2:0] UART_STATUS_OFS = 3'h4;

  // Status register bits
  localparam int STATUS_BUSY = 0;

  // Start bit, 8 data bits LSB first, stop bit
  localparam int FRAME_BITS = 10;

endpackage

// File: uart_tx.sv
module uart_tx import bus_pkg::*, uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clock_50,
  input  logic  rst,
  input  logic  reg_sel,
  input  word_t writedata,
  input  be_t   be,
  input  logic  uart_read,
  input  logic  uart_write,
  output word_t uart_readdata,
  output logic  tx
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int BIT_W = $clog2(FRAME_BITS);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(FRAME_BITS - 1);

  logic                  busy;
  logic [FRAME_BITS-1:0] shift_reg;
  logic [CNT_W-1:0]      clk_cnt;
  logic [BIT_W-1:0]      bit_cnt;
  logic                  sel_data;
  logic                  sel_status;
  logic                  load;
  word_t                 status_word;

  assign sel_data   = (reg_sel == UART_DATA_OFS[2]);
  assign sel_status = (reg_sel == UART_STATUS_OFS[2]);

  // Writes while a frame is on the line are dropped
  assign load = uart_write && sel_data && be[0] && !busy;

  always_ff @(posedge clock_50) begin
    if (rst) begin
      busy      <= 1'b0;
      shift_reg <= '1;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
    end else if (load) begin
      busy      <= 1'b1;
      shift_reg <= {1'b1, writedata[7:0], 1'b0};
      clk_cnt   <= '0;
      bit_cnt   <= '0;
    end else if (busy) begin
      if (clk_cnt == CNT_LAST) begin
        clk_cnt <= '0;
        if (bit_cnt == BIT_LAST) begin
          // Stop bit done, line idles high
          busy <= 1'b0;
        end else begin
          bit_cnt   <= bit_cnt + 1'b1;
          shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // Stop bit stays in bit 0 once the frame ends
  assign tx = shift_reg[0];

  always_comb begin
    status_word = '0;
    status_word[STATUS_BUSY] = busy;
  end

  // Data register is write only
  assign uart_readdata = (uart_read && sel_status) ? status_word : '0;

endmodule
